// ==== src/csrPkg.sv ====
`default_nettype none

package csrPkg;

  localparam int XLEN = 32;
  localparam int CSR_ADDR_W = 12;
  localparam int CNT_W = 64;
  localparam int RETIRE_W = 4;
  localparam int RETIRE_CNT_W = $clog2(RETIRE_W + 1);

  localparam logic [XLEN-1:0] RESET_VECTOR = 32'h8000_0000;
  localparam logic [XLEN-1:0] MISA_VALUE = 32'h4010_1100; // rv32 i m u
  localparam logic [XLEN-1:0] MARCHID_VALUE = 32'h0000_0019;
  localparam logic [XLEN-1:0] MIMPID_VALUE = 32'h0001_0000;

  // bit positions in mip / mie
  localparam int IRQ_MSI = 3;
  localparam int IRQ_MTI = 7;
  localparam int IRQ_MEI = 11;

  typedef enum logic [1:0] {
    PRIV_USER = 2'd0,
    PRIV_MACHINE = 2'd3
  } privLevel_e;

  typedef enum logic [CSR_ADDR_W-1:0] {
    CSR_MSTATUS = 12'h300,
    CSR_MISA = 12'h301,
    CSR_MIE = 12'h304,
    CSR_MTVEC = 12'h305,
    CSR_MCOUNTEREN = 12'h306,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH = 12'h340,
    CSR_MEPC = 12'h341,
    CSR_MCAUSE = 12'h342,
    CSR_MTVAL = 12'h343,
    CSR_MIP = 12'h344,
    CSR_MCYCLE = 12'hB00,
    CSR_MINSTRET = 12'hB02,
    CSR_MCYCLEH = 12'hB80,
    CSR_MINSTRETH = 12'hB82,
    CSR_CYCLE = 12'hC00,
    CSR_TIME = 12'hC01,
    CSR_INSTRET = 12'hC02,
    CSR_CYCLEH = 12'hC80,
    CSR_TIMEH = 12'hC81,
    CSR_INSTRETH = 12'hC82,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID = 12'hF12,
    CSR_MIMPID = 12'hF13,
    CSR_MHARTID = 12'hF14
  } csrAddr_e;

  typedef enum logic [2:0] {
    OP_R = 3'd0,
    OP_RW = 3'd1,
    OP_RS = 3'd2,
    OP_RC = 3'd3,
    OP_RW_I = 3'd4,
    OP_RS_I = 3'd5,
    OP_RC_I = 3'd6,
    OP_MRET = 3'd7
  } csrOpcode_e;

  typedef enum logic [1:0] {
    FLAGS_NONE = 2'd0,
    FLAGS_ORDERING = 2'd1,
    FLAGS_XRET = 2'd2,
    FLAGS_ILLEGAL = 2'd3
  } resultFlags_e;

  // only mie, mpie and mpp are kept, rest reads zero
  typedef struct packed {
    logic sd;
    logic [7:0] wpri23;
    logic tsr;
    logic tw;
    logic tvm;
    logic mxr;
    logic sum;
    logic mprv;
    logic [1:0] xs;
    logic [1:0] fs;
    privLevel_e mpp;
    logic [1:0] vs;
    logic spp;
    logic mpie;
    logic ube;
    logic spie;
    logic wpri4;
    logic mie;
    logic wpri2;
    logic sie;
    logic wpri0;
  } mstatus_t;

  typedef struct packed {
    logic valid;
    csrOpcode_e opcode;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0] srcA;
    logic [4:0] zimm;
    logic writesReg;
    logic [5:0] tag;
  } csrOp_t;

  typedef struct packed {
    logic valid;
    resultFlags_e flags;
    logic [5:0] tag;
    logic [XLEN-1:0] value;
  } csrResult_t;

  typedef struct packed {
    logic valid;
    csrAddr_e addr;
    logic [XLEN-1:0] data;
  } csrWrite_t;

  typedef struct packed {
    logic valid;
    logic isInterrupt;
    logic [4:0] cause;
    logic [XLEN-1:0] trapPC;
    logic [XLEN-1:0] tval;
  } trapInfo_t;

  typedef struct packed {
    privLevel_e priv;
    logic [29:0] mtvecBase;
    logic [30:0] retvec;
    logic interruptPending;
    logic [3:0] interruptCause;
  } trapCtrl_t;

  typedef struct packed {
    mstatus_t mstatus;
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] mcause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mscratch;
    logic [15:0] mie;
    logic [15:0] mip;
    logic [XLEN-1:0] mcounteren;
  } machineRegs_t;

  typedef struct packed {
    logic [CNT_W-1:0] mcycle;
    logic [CNT_W-1:0] minstret;
    logic [XLEN-1:0] mcountinhibit;
  } counters_t;

endpackage

`default_nettype wire

// ==== src/csrOpExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrOpExec
  import csrPkg::*;
(
  input wire clk,
  input wire rst,
  input wire en,
  input csrOp_t op,
  input privLevel_e priv,
  input privLevel_e mpp,
  input wire [XLEN-1:0] rdata,
  input wire invalid,
  output csrWrite_t csrWr,
  output logic mretStrobe,
  output csrResult_t result
);

  logic accept;
  logic isMret;
  logic isWrite;
  logic isImm;
  logic csrIllegal;
  logic mretIllegal;
  logic [XLEN-1:0] operand;
  logic [XLEN-1:0] wdata;
  resultFlags_e flags;

  assign accept = en && op.valid;
  assign isMret = op.opcode == OP_MRET;
  assign isWrite = !isMret && op.opcode != OP_R;
  assign isImm = op.opcode inside {OP_RW_I, OP_RS_I, OP_RC_I};
  assign operand = isImm ? {{(XLEN-5){1'b0}}, op.zimm} : op.srcA;

  // addr[9:8] is the lowest privilege allowed, addr[11:10] == 3 means read-only
  assign csrIllegal = (priv < op.addr[9:8]) || invalid ||
                      (isWrite && op.addr[11:10] == 2'b11);

  // mpp may hold an unimplemented level after a software write
  assign mretIllegal = (priv != PRIV_MACHINE) || !(mpp inside {PRIV_USER, PRIV_MACHINE});

  always_comb begin
    case (op.opcode)
      OP_RW, OP_RW_I: wdata = operand;
      OP_RS, OP_RS_I: wdata = rdata | operand;
      OP_RC, OP_RC_I: wdata = rdata & ~operand;
      default: wdata = rdata;
    endcase
  end

  always_comb begin
    flags = FLAGS_NONE;
    if (isMret)
      flags = mretIllegal ? FLAGS_ILLEGAL : FLAGS_XRET;
    else if (csrIllegal)
      flags = FLAGS_ILLEGAL;
    else if (isWrite && op.addr inside {CSR_MSTATUS, CSR_MIE, CSR_MIP, CSR_MCOUNTEREN})
      flags = FLAGS_ORDERING; // read out of order elsewhere in the core
  end

  // receivers update on the accepting edge
  assign csrWr.valid = accept && isWrite && !csrIllegal;
  assign csrWr.addr = csrAddr_e'(op.addr);
  assign csrWr.data = wdata;
  assign mretStrobe = accept && isMret && !mretIllegal;

  always_ff @(posedge clk) begin
    if (rst) begin
      result.valid <= 1'b0;
    end else begin
      result.valid <= accept;
      if (accept) begin
        result.flags <= flags;
        result.tag <= op.tag;
        if (op.writesReg)
          result.value <= rdata; // old value
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/csrReadMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrReadMux
  import csrPkg::*;
(
  input csrAddr_e addr,
  input machineRegs_t regs,
  input counters_t counters,
  input privLevel_e priv,
  input wire [CNT_W-1:0] mtime,
  output logic [XLEN-1:0] rdata,
  output logic invalid
);

  logic hiHalf;
  logic userBlocked;

  function automatic logic [XLEN-1:0] pickHalf(input logic [CNT_W-1:0] value, input logic hi);
    return hi ? value[CNT_W-1:XLEN] : value[XLEN-1:0];
  endfunction

  assign hiHalf = addr[7]; // the ...h addresses
  // cycle, time, instret map onto mcounteren bits 0..2
  assign userBlocked = (priv == PRIV_USER) && !regs.mcounteren[addr[1:0]];

  always_comb begin
    rdata = '0;
    invalid = 1'b0;
    case (addr)
      CSR_CYCLE, CSR_CYCLEH: begin
        rdata = pickHalf(counters.mcycle, hiHalf);
        invalid = userBlocked;
      end
      CSR_TIME, CSR_TIMEH: begin
        rdata = pickHalf(mtime, hiHalf);
        invalid = userBlocked;
      end
      CSR_INSTRET, CSR_INSTRETH: begin
        rdata = pickHalf(counters.minstret, hiHalf);
        invalid = userBlocked;
      end
      CSR_MCYCLE, CSR_MCYCLEH: rdata = pickHalf(counters.mcycle, hiHalf);
      CSR_MINSTRET, CSR_MINSTRETH: rdata = pickHalf(counters.minstret, hiHalf);
      CSR_MCOUNTINHIBIT: rdata = counters.mcountinhibit;

      CSR_MISA: rdata = MISA_VALUE;
      CSR_MARCHID: rdata = MARCHID_VALUE;
      CSR_MIMPID: rdata = MIMPID_VALUE;
      CSR_MVENDORID, CSR_MHARTID: rdata = '0; // single hart, no vendor id

      CSR_MSTATUS: rdata = regs.mstatus;
      CSR_MTVEC: rdata = regs.mtvec;
      CSR_MEPC: rdata = regs.mepc;
      CSR_MCAUSE: rdata = regs.mcause;
      CSR_MTVAL: rdata = regs.mtval;
      CSR_MSCRATCH: rdata = regs.mscratch;
      CSR_MIE: rdata = {16'b0, regs.mie};
      CSR_MIP: rdata = {16'b0, regs.mip};
      CSR_MCOUNTEREN: rdata = regs.mcounteren;
      default: invalid = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/machineState.sv ====
`timescale 1ns/1ps
`default_nettype none

module machineState
  import csrPkg::*;
(
  input wire clk,
  input wire rst,
  input wire irq,
  input wire [CNT_W-1:0] mtime,
  input wire [CNT_W-1:0] mtimecmp,
  input trapInfo_t trapIn,
  input csrWrite_t csrWr,
  input wire mretStrobe,
  output machineRegs_t regs,
  output trapCtrl_t trapCtrl
);

  privLevel_e priv;
  logic [30:0] retvec;
  mstatus_t wrStatus;
  logic [15:0] active;
  logic globalEnable;
  logic irqPending;
  logic [3:0] irqCause;

  assign wrStatus = csrWr.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '0;
      regs.mtvec <= RESET_VECTOR;
      priv <= PRIV_MACHINE;
      retvec <= '0;
    end else begin
      regs.mip[IRQ_MTI] <= mtime >= mtimecmp;
      regs.mip[IRQ_MEI] <= irq;

      if (trapIn.valid) begin
        regs.mepc <= trapIn.trapPC;
        regs.mcause <= {trapIn.isInterrupt, 26'b0, trapIn.cause};
        regs.mtval <= trapIn.tval;
        regs.mstatus.mpie <= regs.mstatus.mie;
        regs.mstatus.mie <= 1'b0;
        regs.mstatus.mpp <= priv;
        priv <= PRIV_MACHINE;
      end else if (mretStrobe) begin
        regs.mstatus.mie <= regs.mstatus.mpie;
        regs.mstatus.mpie <= 1'b1;
        regs.mstatus.mpp <= PRIV_USER;
        priv <= regs.mstatus.mpp;
        retvec <= regs.mepc[31:1];
      end else if (csrWr.valid) begin
        case (csrWr.addr)
          CSR_MSTATUS: begin
            regs.mstatus.mie <= wrStatus.mie;
            regs.mstatus.mpie <= wrStatus.mpie;
            regs.mstatus.mpp <= wrStatus.mpp;
          end
          CSR_MTVEC: regs.mtvec <= {csrWr.data[31:2], 2'b00}; // direct mode only
          CSR_MEPC: regs.mepc <= {csrWr.data[31:1], 1'b0};
          CSR_MCAUSE: regs.mcause <= {csrWr.data[31], 26'b0, csrWr.data[4:0]};
          CSR_MTVAL: regs.mtval <= csrWr.data;
          CSR_MSCRATCH: regs.mscratch <= csrWr.data;
          CSR_MCOUNTEREN: regs.mcounteren <= csrWr.data;
          CSR_MIE: begin
            regs.mie[IRQ_MSI] <= csrWr.data[IRQ_MSI];
            regs.mie[IRQ_MTI] <= csrWr.data[IRQ_MTI];
            regs.mie[IRQ_MEI] <= csrWr.data[IRQ_MEI];
          end
          default: ; // mip is driven by hardware only
        endcase
      end
    end
  end

  assign active = regs.mip & regs.mie;
  assign globalEnable = (priv == PRIV_USER) || regs.mstatus.mie;

  // priority mei > msi > mti
  always_comb begin
    irqPending = 1'b0;
    irqCause = '0;
    if (globalEnable) begin
      if (active[IRQ_MEI]) begin
        irqPending = 1'b1;
        irqCause = 4'(IRQ_MEI);
      end else if (active[IRQ_MSI]) begin
        irqPending = 1'b1;
        irqCause = 4'(IRQ_MSI);
      end else if (active[IRQ_MTI]) begin
        irqPending = 1'b1;
        irqCause = 4'(IRQ_MTI);
      end
    end
  end

  assign trapCtrl.priv = priv;
  assign trapCtrl.mtvecBase = regs.mtvec[31:2];
  assign trapCtrl.retvec = retvec;
  assign trapCtrl.interruptPending = irqPending;
  assign trapCtrl.interruptCause = irqCause;

endmodule

`default_nettype wire

// ==== src/perfCounters.sv ====
`timescale 1ns/1ps
`default_nettype none

module perfCounters
  import csrPkg::*;
(
  input wire clk,
  input wire rst,
  input wire [RETIRE_W-1:0] retireMask,
  input csrWrite_t csrWr,
  output counters_t counters
);

  logic [RETIRE_CNT_W-1:0] retired;

  always_comb begin
    retired = '0;
    for (int i = 0; i < RETIRE_W; i++)
      retired = retired + RETIRE_CNT_W'(retireMask[i]);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      counters <= '0;
    end else begin
      if (!counters.mcountinhibit[0])
        counters.mcycle <= counters.mcycle + CNT_W'(1);
      if (!counters.mcountinhibit[2])
        counters.minstret <= counters.minstret + CNT_W'(retired);

      // software write replaces the increment on this edge
      if (csrWr.valid) begin
        case (csrWr.addr)
          CSR_MCYCLE: counters.mcycle <= {counters.mcycle[CNT_W-1:XLEN], csrWr.data};
          CSR_MCYCLEH: counters.mcycle <= {csrWr.data, counters.mcycle[XLEN-1:0]};
          CSR_MINSTRET: counters.minstret <= {counters.minstret[CNT_W-1:XLEN], csrWr.data};
          CSR_MINSTRETH: counters.minstret <= {csrWr.data, counters.minstret[XLEN-1:0]};
          CSR_MCOUNTINHIBIT:
            counters.mcountinhibit <= {{(XLEN-3){1'b0}}, csrWr.data[2], 1'b0, csrWr.data[0]};
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/csrUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrUnit
  import csrPkg::*;
(
  input wire clk,
  input wire rst,
  input wire en,
  input wire irq,
  input wire [CNT_W-1:0] mtime,
  input wire [CNT_W-1:0] mtimecmp,
  input csrOp_t op,
  input wire [RETIRE_W-1:0] retireMask,
  input trapInfo_t trapIn,
  output csrResult_t result,
  output trapCtrl_t trapCtrl
);

  machineRegs_t regs;
  counters_t counters;
  csrWrite_t csrWr;
  logic mretStrobe;
  logic [XLEN-1:0] rdata;
  logic invalid;

  csrOpExec opExec_i (
    .clk(clk),
    .rst(rst),
    .en(en),
    .op(op),
    .priv(trapCtrl.priv),
    .mpp(regs.mstatus.mpp),
    .rdata(rdata),
    .invalid(invalid),
    .csrWr(csrWr),
    .mretStrobe(mretStrobe),
    .result(result)
  );

  csrReadMux readMux_i (
    .addr(csrAddr_e'(op.addr)),
    .regs(regs),
    .counters(counters),
    .priv(trapCtrl.priv),
    .mtime(mtime),
    .rdata(rdata),
    .invalid(invalid)
  );

  machineState machState_i (
    .clk(clk),
    .rst(rst),
    .irq(irq),
    .mtime(mtime),
    .mtimecmp(mtimecmp),
    .trapIn(trapIn),
    .csrWr(csrWr),
    .mretStrobe(mretStrobe),
    .regs(regs),
    .trapCtrl(trapCtrl)
  );

  perfCounters perfCnt_i (
    .clk(clk),
    .rst(rst),
    .retireMask(retireMask),
    .csrWr(csrWr),
    .counters(counters)
  );

endmodule

`default_nettype wire

// ==== testbench/csrUnitTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module csrUnitTb
  import csrPkg::*;
();

  logic clk;
  logic rst;
  logic en;
  logic irq;
  logic [CNT_W-1:0] mtime;
  logic [CNT_W-1:0] mtimecmp;
  csrOp_t op;
  logic [RETIRE_W-1:0] retireMask;
  trapInfo_t trapIn;
  csrResult_t result;
  trapCtrl_t trapCtrl;

  int errorCount;
  int checkCount;
  int lineCount;
  int lineNo;
  bit linesCounted;
  logic [5:0] tag;

  csrUnit dut_i (
    .clk(clk),
    .rst(rst),
    .en(en),
    .irq(irq),
    .mtime(mtime),
    .mtimecmp(mtimecmp),
    .op(op),
    .retireMask(retireMask),
    .trapIn(trapIn),
    .result(result),
    .trapCtrl(trapCtrl)
  );

  always #10 clk = ~clk;

  task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("Error at %0t: %s is %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // op goes in on one edge, is accepted on the next, result is read half a cycle later
  task automatic runOp(input logic [63:0] opc, input logic [63:0] addr, input logic [63:0] srcA,
                       input logic [63:0] zimm, input logic [63:0] wr,
                       input logic [63:0] expFlags, input logic [63:0] expValue);
    @(posedge clk);
    op.valid <= 1'b1;
    op.opcode <= csrOpcode_e'(opc[2:0]);
    op.addr <= addr[CSR_ADDR_W-1:0];
    op.srcA <= srcA[XLEN-1:0];
    op.zimm <= zimm[4:0];
    op.writesReg <= wr[0];
    op.tag <= tag;
    @(posedge clk);
    op.valid <= 1'b0;
    @(negedge clk);
    checkValue(32'(result.valid), 32'd1, $sformatf("line %0d result valid", lineNo));
    checkValue(32'(result.flags), expFlags[31:0], $sformatf("line %0d flags", lineNo));
    checkValue(32'(result.tag), 32'(tag), $sformatf("line %0d tag", lineNo));
    checkValue(result.value, expValue[31:0], $sformatf("line %0d value", lineNo));
    tag = tag + 6'd1;
  endtask

  task automatic raiseTrap(input logic [63:0] isIrq, input logic [63:0] cause,
                           input logic [63:0] pc, input logic [63:0] tval);
    @(posedge clk);
    trapIn <= {1'b1, isIrq[0], cause[4:0], pc[XLEN-1:0], tval[XLEN-1:0]};
    @(posedge clk);
    trapIn.valid <= 1'b0;
  endtask

  task automatic pulseRetire(input logic [63:0] mask);
    @(posedge clk);
    retireMask <= mask[RETIRE_W-1:0];
    @(posedge clk);
    retireMask <= '0;
  endtask

  task automatic setTimer(input logic [63:0] now, input logic [63:0] cmp, input logic [63:0] ext);
    @(posedge clk);
    mtime <= now;
    mtimecmp <= cmp;
    irq <= ext[0];
  endtask

  initial begin
    int fd;
    string line;
    byte cmd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    logic [63:0] e;
    logic [63:0] f;
    logic [63:0] g;

    clk = 1'b0;
    rst = 1'b1;
    en = 1'b1;
    irq = 1'b0;
    mtime = '0;
    mtimecmp = '1; // no timer interrupt until a test asks for one
    op = '0;
    retireMask = '0;
    trapIn = '0;
    errorCount = 0;
    checkCount = 0;
    lineCount = 0;
    lineNo = 0;
    tag = '0;

    fd = $fopen("testbench/csrInput.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file testbench/csrInput.txt");
      errorCount++;
    end else begin
      while ($fgets(line, fd) > 0)
        lineCount++;
      linesCounted = 1'b1;
      $fclose(fd);
      fd = $fopen("testbench/csrInput.txt", "r");

      repeat (16) @(posedge clk);
      rst <= 1'b0;

      // state right out of reset
      @(negedge clk);
      checkValue(32'(result.valid), 32'd0, "result valid after reset");
      checkValue(32'(trapCtrl.interruptPending), 32'd0, "interrupt pending after reset");
      checkValue(32'(trapCtrl.priv), 32'(PRIV_MACHINE), "priv after reset");
      checkValue(32'(trapCtrl.mtvecBase), 32'(RESET_VECTOR >> 2), "mtvecBase after reset");
      checkValue(32'(trapCtrl.retvec), 32'd0, "retvec after reset");

      while ($fgets(line, fd) > 0) begin
        lineNo++;
        if (line.len() < 2 || line[0] == "#")
          continue;
        a = '0;
        b = '0;
        c = '0;
        d = '0;
        e = '0;
        f = '0;
        g = '0;
        void'($sscanf(line, "%c %h %h %h %h %h %h %h", cmd, a, b, c, d, e, f, g));
        case (cmd)
          "O": runOp(a, b, c, d, e, f, g);
          "T": raiseTrap(a, b, c, d);
          "R": pulseRetire(a);
          "M": setTimer(a, b, c);
          "W": repeat (a[15:0]) @(posedge clk);
          "I": begin
            @(negedge clk);
            checkValue(32'(result.valid), 32'd0, $sformatf("line %0d result valid", lineNo));
            checkValue(32'(trapCtrl.interruptPending), a[31:0],
                       $sformatf("line %0d interrupt pending", lineNo));
            if (a[0])
              checkValue(32'(trapCtrl.interruptCause), b[31:0],
                         $sformatf("line %0d interrupt cause", lineNo));
          end
          "V": begin
            @(negedge clk);
            checkValue(32'(result.valid), 32'd0, $sformatf("line %0d result valid", lineNo));
            checkValue(32'(trapCtrl.priv), a[31:0], $sformatf("line %0d priv", lineNo));
            checkValue(32'(trapCtrl.retvec), b[31:0], $sformatf("line %0d retvec", lineNo));
          end
          default: begin
            $display("unknown command on line %0d of the stimulus file", lineNo);
            errorCount++;
          end
        endcase
      end
      $fclose(fd);
      repeat (2) @(posedge clk);
    end

    $display("checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

  // budget of 8 cycles per stimulus line plus reset
  initial begin
    wait (linesCounted);
    #((lineCount * 8 + 16) * 20);
    $display("timeout: the stimulus did not finish within %0d cycles", lineCount * 8 + 16);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/csrInput.txt ====
# hex fields. O opcode addr srcA zimm writesReg flags value | T isInterrupt cause pc tval
# R mask | M mtime mtimecmp irq | I pending cause | V priv retvec | W cycles
O 1 340 12345678 00 1 0 00000000
O 5 340 00000000 0f 1 0 12345678
O 3 340 00000070 00 1 0 1234567f
O 2 340 f0000000 00 0 0 1234567f
O 6 340 00000000 03 1 0 f234560f
O 4 340 00000000 1a 1 0 f234560c
O 0 340 00000000 00 1 0 0000001a
O 1 f12 00000001 00 0 3 0000001a
O 0 7c0 00000000 00 0 3 0000001a
O 0 301 00000000 00 1 0 40101100
O 0 f13 00000000 00 1 0 00010000
O 1 300 00000008 00 1 1 00000000
O 1 320 00000005 00 1 0 00000000
O 1 b00 00000100 00 0 0 00000000
O 1 b02 00000200 00 0 0 00000000
W 3
O 0 b00 00000000 00 1 0 00000100
O 0 b02 00000000 00 1 0 00000200
O 6 320 00000000 04 1 0 00000005
R f
R 3
O 0 b02 00000000 00 1 0 00000206
T 0 2 00001004 deadbeef
O 0 341 00000000 00 1 0 00001004
O 0 342 00000000 00 1 0 00000002
O 0 343 00000000 00 1 0 deadbeef
O 0 300 00000000 00 1 0 00001880
O 3 300 00001800 00 0 1 00001880
O 7 000 00000000 00 0 2 00001880
V 0 00000802
O 0 300 00000000 00 0 3 00001880
O 0 c00 00000000 00 0 3 00001880
O 7 000 00000000 00 0 3 00001880
T 0 8 00002000 00000000
O 4 306 00000000 01 0 1 00001880
O 0 300 00000000 00 1 0 00000080
O 7 000 00000000 00 0 2 00000080
V 0 00001000
O 0 c00 00000000 00 0 0 00000080
T 0 8 00002008 00000000
O 1 304 00000880 00 0 1 00000080
O 5 300 00000000 08 1 1 00000080
M 0000000000000100 00000000000000f0 0
W 2
I 1 7
M 0000000000000100 00000000000000f0 1
W 2
I 1 b
O 6 300 00000000 08 1 1 00000088
I 0 0

// ==== sources.f ====
src/csrPkg.sv
src/csrOpExec.sv
src/csrReadMux.sv
src/machineState.sv
src/perfCounters.sv
src/csrUnit.sv
testbench/csrUnitTb.sv

// ==== Makefile ====
TOP = csrUnitTb

.PHONY: sim clean

sim:
	verilator --binary --timing -f sources.f --top-module $(TOP) --Mdir obj_dir -o simv
	out=$$(./obj_dir/simv); echo "$$out"; echo "$$out" | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
